//--- include/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

`define CLK_MHZ      50   // board oscillator

`define W_KEY        4
`define W_LED        8
`define W_DIGIT      8
`define W_GPIO       16

`define SCK_DIV      2    // clk cycles per sck half period
`define FIFO_DEPTH   4    // sample entries
`define PEAK_WINDOW  4    // samples per peak window
`define SCAN_DIV     8    // clk cycles each digit stays lit

`endif

//--- src/audio_pkg.sv
package audio_pkg;

    localparam int SAMPLE_BITS = 24;  // INMP441 word length

    // one left channel word, two's complement
    typedef struct packed {
        logic signed [SAMPLE_BITS-1:0] value;
    } mic_sample_t;

    // absolute value of a sample, never above MAG_MAX
    typedef logic [SAMPLE_BITS-1:0] magnitude_t;

    localparam magnitude_t MAG_MAX =
        {1'b0, {(SAMPLE_BITS - 1){1'b1}}};

    // most negative sample, has no positive counterpart
    localparam logic [SAMPLE_BITS-1:0] SAMPLE_MIN =
        {1'b1, {(SAMPLE_BITS - 1){1'b0}}};

endpackage

//--- src/board_pkg.sv
`include "board_settings.svh"

package board_pkg;

    // LED word, overflow sits on the top LED
    typedef struct packed {
        logic              overflow;  // sticky FIFO drop
        logic [`W_LED-2:0] bar;       // level bar, bit 0 lights first
    } led_bar_t;

    // segments a..g in bits 7..1, dot in bit 0, active high
    typedef logic [7:0] seg_pattern_t;

    localparam seg_pattern_t SEG_BLANK = '0;

endpackage

//--- src/inmp441_mic_i2s_receiver.sv
`include "board_settings.svh"

module inmp441_mic_i2s_receiver (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output audio_pkg::mic_sample_t sample,
    output logic                   sample_strobe
);

    import audio_pkg::*;

    localparam int DIV_W     = $clog2(`SCK_DIV + 1);
    localparam int FRAME_SCK = 64;                // sck periods per stereo frame
    localparam int HALF_SCK  = FRAME_SCK / 2;
    localparam int BIT_W     = $clog2(FRAME_SCK);

    logic [DIV_W-1:0]       div_cnt;
    logic [BIT_W-1:0]       bit_cnt;   // sck period within the frame
    logic [BIT_W-1:0]       bit_next;
    logic [SAMPLE_BITS-1:0] shreg;
    logic                   ws_prev;
    logic                   div_end;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   in_slot;
    logic                   ws_rise;

    assign div_end  = (div_cnt == DIV_W'(`SCK_DIV - 1));
    assign sck_rise = div_end & ~sck;
    assign sck_fall = div_end & sck;
    assign bit_next = bit_cnt + 1'b1;    // wraps at the frame end
    assign ws_rise  = ws & ~ws_prev;

    // period 0 after the ws fall is the I2S delay slot, then MSB first
    assign in_slot = ~ws && (bit_cnt >= 1) && (bit_cnt <= SAMPLE_BITS);

    // ws changes together with the sck falling edge
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
        end else if (div_end) begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck_fall) begin
                bit_cnt <= bit_next;
                ws      <= (bit_next >= HALF_SCK);  // right half of the frame
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise && in_slot)
            shreg <= {shreg[SAMPLE_BITS-2:0], sd};
        if (ws_rise)
            sample.value <= shreg;  // left word is complete by now
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_prev       <= 1'b0;
            sample_strobe <= 1'b0;
        end else begin
            ws_prev       <= ws;
            sample_strobe <= ws_rise;
        end
    end

endmodule

//--- src/sample_fifo.sv
`include "board_settings.svh"

module sample_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     write,
    input  payload_t data_in,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     overflow
);

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_write;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_write = write & ~full;   // a write into a full FIFO is lost
    assign do_pop   = pop & ~empty;
    assign head     = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_write && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_write)
                count <= count - 1'b1;
            if (write && full)
                overflow <= 1'b1;  // stays until reset
        end
    end

endmodule

//--- src/level_meter.sv
`include "board_settings.svh"

module level_meter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   hold,
    input  audio_pkg::mic_sample_t head,
    input  logic                   empty,
    input  logic                   overflow,
    output logic                   pop,
    output audio_pkg::magnitude_t  peak,
    output board_pkg::led_bar_t    led_bar
);

    import audio_pkg::*;

    localparam int WIN_W    = $clog2(`PEAK_WINDOW + 1);
    localparam int BAR_BITS = `W_LED - 1;
    localparam int BAR_BASE = SAMPLE_BITS - BAR_BITS - 1;  // bit 16 lights nothing
    localparam int LEN_W    = $clog2(BAR_BITS + 1);
    localparam logic [BAR_BITS-1:0] ALL_ONES = '1;

    logic [WIN_W-1:0] win_cnt;   // pops so far in this window
    magnitude_t       mag;
    magnitude_t       run_max;
    magnitude_t       win_max;
    logic [LEN_W-1:0] bar_len;

    assign pop = ~empty & ~hold;

    always_comb begin
        if (!head.value[SAMPLE_BITS-1])
            mag = magnitude_t'(head.value);
        else if (head.value == SAMPLE_MIN)
            mag = MAG_MAX;                  // saturate, -min does not fit
        else
            mag = magnitude_t'(-head.value);
    end

    assign win_max = (mag > run_max) ? mag : run_max;

    always_ff @(posedge clk) begin
        if (reset) begin
            win_cnt <= '0;
            run_max <= '0;
            peak    <= '0;
        end else if (pop) begin
            if (win_cnt == WIN_W'(`PEAK_WINDOW - 1)) begin
                peak    <= win_max;  // last sample of the window counts too
                run_max <= '0;
                win_cnt <= '0;
            end else begin
                run_max <= win_max;
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

    // bar length follows the leading one of peak
    always_comb begin
        bar_len = '0;
        for (int i = BAR_BASE + 1; i < SAMPLE_BITS; i++) begin
            if (peak[i])
                bar_len = LEN_W'(i - BAR_BASE);
        end
        led_bar.overflow = overflow;
        led_bar.bar      = ~(ALL_ONES << bar_len);
    end

endmodule

//--- src/seg7_display.sv
`include "board_settings.svh"

module seg7_display (
    input  logic                    clk,
    input  logic                    reset,
    input  audio_pkg::magnitude_t   peak,
    output board_pkg::seg_pattern_t abcdefgh,
    output logic [`W_DIGIT-1:0]     digit
);

    import board_pkg::*;

    localparam int SCAN_W     = $clog2(`SCAN_DIV);
    localparam int IDX_W      = $clog2(`W_DIGIT);
    localparam int HEX_DIGITS = $bits(peak) / 4;  // upper digits stay dark

    logic [SCAN_W-1:0] scan_cnt;
    logic [IDX_W-1:0]  digit_idx;
    logic [3:0]        nibble;

    function automatic seg_pattern_t hex_to_seg(input logic [3:0] hex);
        case (hex)
            4'h0:    return 8'b1111_1100;
            4'h1:    return 8'b0110_0000;
            4'h2:    return 8'b1101_1010;
            4'h3:    return 8'b1111_0010;
            4'h4:    return 8'b0110_0110;
            4'h5:    return 8'b1011_0110;
            4'h6:    return 8'b1011_1110;
            4'h7:    return 8'b1110_0000;
            4'h8:    return 8'b1111_1110;
            4'h9:    return 8'b1111_0110;
            4'ha:    return 8'b1110_1110;
            4'hb:    return 8'b0011_1110;  // lower case b
            4'hc:    return 8'b1001_1100;
            4'hd:    return 8'b0111_1010;  // lower case d
            4'he:    return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(`SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= (digit_idx == IDX_W'(`W_DIGIT - 1)) ? '0 : digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        nibble          = 4'(peak >> {digit_idx, 2'b00});
        digit           = '0;
        digit[digit_idx] = 1'b1;  // one enable at a time
        abcdefgh        = (digit_idx < HEX_DIGITS) ? hex_to_seg(nibble) : SEG_BLANK;
    end

endmodule

//--- src/top.sv
`include "board_settings.svh"

module top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`W_KEY-2:0]       key,
    input  audio_pkg::mic_sample_t  sample,
    input  logic                    sample_strobe,
    output board_pkg::led_bar_t     led,
    output board_pkg::seg_pattern_t abcdefgh,
    output logic [`W_DIGIT-1:0]     digit
);

    import audio_pkg::*;

    mic_sample_t head;
    magnitude_t  peak;
    logic        empty;
    logic        overflow;
    logic        pop;

    sample_fifo #(
        .payload_t ( mic_sample_t )
    ) i_fifo (
        .clk      ( clk           ),
        .reset    ( reset         ),
        .write    ( sample_strobe ),
        .data_in  ( sample        ),
        .pop      ( pop           ),
        .head     ( head          ),
        .empty    ( empty         ),
        .overflow ( overflow      )
    );

    level_meter i_meter (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .hold     ( key[0]   ),  // pressed key lets the FIFO fill
        .head     ( head     ),
        .empty    ( empty    ),
        .overflow ( overflow ),
        .pop      ( pop      ),
        .peak     ( peak     ),
        .led_bar  ( led      )
    );

    seg7_display i_display (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .peak     ( peak     ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

//--- src/board_specific_top.sv
`include "board_settings.svh"

module board_specific_top (
    input  logic                CLK,
    input  logic [`W_KEY-1:0]   KEY,
    output logic [`W_LED-1:0]   LED,
    output logic [7:0]          ABCDEFGH,
    output logic [`W_DIGIT-1:0] DIGIT,
    inout  wire  [`W_GPIO-1:0]  GPIO
);

    import audio_pkg::*;
    import board_pkg::*;

    localparam int W_TOP_KEY = `W_KEY - 1;  // top key is reset

    logic                  clk;
    logic                  reset;
    logic [W_TOP_KEY-1:0]  top_key;
    mic_sample_t           mic_sample;
    logic                  mic_strobe;
    logic                  mic_sck;
    logic                  mic_ws;
    led_bar_t              led;
    seg_pattern_t          abcdefgh;
    logic [`W_DIGIT-1:0]   digit;

    assign clk     = CLK;
    assign reset   = ~KEY[W_TOP_KEY];
    assign top_key = ~KEY[W_TOP_KEY-1:0];

    top i_top (
        .clk           ( clk        ),
        .reset         ( reset      ),
        .key           ( top_key    ),
        .sample        ( mic_sample ),
        .sample_strobe ( mic_strobe ),
        .led           ( led        ),
        .abcdefgh      ( abcdefgh   ),
        .digit         ( digit      )
    );

    // board drives are all active low
    assign LED      = ~led;
    assign ABCDEFGH = ~abcdefgh;
    assign DIGIT    = ~digit;

    inmp441_mic_i2s_receiver i_microphone (
        .clk           ( clk        ),
        .reset         ( reset      ),
        .sd            ( GPIO[14]   ),  // P1 pin 21
        .sck           ( mic_sck    ),
        .ws            ( mic_ws     ),
        .sample        ( mic_sample ),
        .sample_strobe ( mic_strobe )
    );

    assign GPIO[15] = mic_sck;  // P1 pin 22
    assign GPIO[13] = mic_ws;   // P1 pin 20
    assign GPIO[11] = 1'b0;     // L/R low selects the left slot
    assign GPIO[10] = 1'b0;     // mic ground
    assign GPIO[12] = 1'b1;     // mic supply

endmodule

//--- tests/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

//--- tests/board_top_props.sv
`include "board_settings.svh"

module board_top_props (
    input logic       clk,
    input logic       reset,
    input logic       pop,
    input logic       empty,
    input logic       overflow,
    input logic [2:0] count
);

    timeunit 1ns;
    timeprecision 100ps;

    count_in_range: assert property (@(posedge clk) disable iff (reset) count <= `FIFO_DEPTH)
        else $error("FIFO count above depth");
    empty_after_reset: assert property (@(posedge clk) reset |=> empty)
        else $error("FIFO not empty after reset");
    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("pop while FIFO empty");
    overflow_sticky: assert property (@(posedge clk) $fell(overflow) |-> $past(reset))
        else $error("overflow cleared without reset");

endmodule

bind sample_fifo board_top_props u_props (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .pop      ( pop      ),
    .empty    ( empty    ),
    .overflow ( overflow ),
    .count    ( count    )
);

//--- tests/tb_board_top.sv
`include "board_settings.svh"

module tb_board_top;

    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;
    import board_pkg::*;

    localparam int TOTAL_FRAMES = 40;  // all tests with their resets
    localparam int FRAME_CLK    = 256;

    logic                clk;
    logic                gen_reset;
    logic                tb_reset;
    logic                hold;
    logic [`W_KEY-1:0]   KEY;
    logic [`W_LED-1:0]   LED;
    logic [7:0]          ABCDEFGH;
    logic [`W_DIGIT-1:0] DIGIT;
    wire  [`W_GPIO-1:0]  GPIO;
    logic                sd;
    int                  errors;
    int                  cyc;        // clk cycles since reset release
    int                  seed;
    mic_sample_t         word_q[$];  // left words still to send
    mic_sample_t         load_q[$];  // words for the frames after the next reset
    mic_sample_t         cur_word;
    int                  pos;
    logic                ws_last;
    seg_pattern_t        shown[8];

    tb_clock_gen u_clk (.clk(clk), .reset(gen_reset));

    board_specific_top u_dut (
        .CLK      ( clk      ),
        .KEY      ( KEY      ),
        .LED      ( LED      ),
        .ABCDEFGH ( ABCDEFGH ),
        .DIGIT    ( DIGIT    ),
        .GPIO     ( GPIO     )
    );

    assign KEY      = {~(gen_reset | tb_reset), 2'b11, ~hold};
    assign GPIO[14] = sd;

    // microphone model, next bit goes out after each sck fall
    always @(negedge GPIO[15]) begin
        #1;
        if (!gen_reset && !tb_reset) begin  // reset pulls sck low without a bit
            if (ws_last && !GPIO[13]) begin
                pos      = 0;
                cur_word = (word_q.size() > 0) ? word_q.pop_front() : '0;
            end else begin
                pos = pos + 1;
            end
            ws_last = GPIO[13];
            sd = (!GPIO[13] && pos >= 1 && pos <= SAMPLE_BITS) ? cur_word.value[SAMPLE_BITS - pos]
                                                                : 1'b0;
        end
    end

    always @(posedge clk) cyc <= cyc + 1;

    // one-hot digit enables, checked on every cycle out of reset
    always @(negedge clk) begin
        if (!gen_reset && !tb_reset && $countones(~DIGIT) != 1) begin
            errors++;
            $display("ERR DIGIT expected one hot actual %h", ~DIGIT);
        end
    end

    function automatic seg_pattern_t hex_seg(input logic [3:0] h);
        seg_pattern_t t[16];
        t = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
              8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E};
        return t[h];
    endfunction

    function automatic magnitude_t abs_sat(input mic_sample_t s);
        if (s.value == 24'sh800000)
            return 24'h7FFFFF;
        return (s.value < 0) ? magnitude_t'(-s.value) : magnitude_t'(s.value);
    endfunction

    function automatic led_bar_t exp_bar(input magnitude_t p, input logic ovf);
        led_bar_t r;
        int       hi;
        int       n;
        hi = -1;
        for (int i = 0; i < SAMPLE_BITS; i++)
            if (p[i])
                hi = i;
        n = hi - 16;
        if (n < 0)
            n = 0;
        if (n > 7)
            n = 7;
        r.overflow = ovf;
        r.bar      = 7'((1 << n) - 1);
        return r;
    endfunction

    function automatic magnitude_t max_mag(input mic_sample_t w[4]);
        magnitude_t m;
        m = '0;
        foreach (w[i])
            if (abs_sat(w[i]) > m)
                m = abs_sat(w[i]);
        return m;
    endfunction

    task automatic queue_words(input mic_sample_t w[4]);
        foreach (w[i])
            load_q.push_back(w[i]);
    endtask

    task automatic do_reset();
        @(posedge clk);
        #2 tb_reset = 1'b1;
        word_q = load_q;  // model is quiet from here until release
        load_q.delete();
        repeat (10) @(posedge clk);
        #2 tb_reset = 1'b0;
        cyc      = 0;
        pos      = 0;
        ws_last  = 1'b0;
        cur_word = (word_q.size() > 0) ? word_q.pop_front() : '0;
    endtask

    task automatic wait_cycle(input int n);
        while (cyc < n)
            @(posedge clk);
    endtask

    task automatic set_hold(input logic v);
        @(posedge clk);
        #2 hold = v;
    endtask

    task automatic read_display();
        int waits;
        for (int i = 0; i < `W_DIGIT; i++) begin
            waits = 0;
            @(negedge clk);
            while (DIGIT !== ~(8'b1 << i) && waits < 4 * `W_DIGIT * `SCAN_DIV) begin
                @(negedge clk);
                waits++;
            end
            if (waits >= 4 * `W_DIGIT * `SCAN_DIV) begin
                errors++;
                $display("digit %0d never became active", i);
            end
            shown[i] = ~ABCDEFGH;
        end
    endtask

    task automatic check_segments(input int idx, input seg_pattern_t exp);
        if (shown[idx] !== exp) begin
            errors++;
            $display("ERR abcdefgh[%0d] expected %h actual %h", idx, exp, shown[idx]);
        end
    endtask

    task automatic check_peak(input magnitude_t exp);
        magnitude_t act;
        logic       found;
        read_display();
        act = '0;
        for (int i = 0; i < 6; i++) begin
            found = 1'b0;
            for (int h = 0; h < 16; h++)
                if (shown[i] === hex_seg(4'(h))) begin
                    act[i*4 +: 4] = 4'(h);
                    found         = 1'b1;
                end
            if (!found) begin
                errors++;
                $display("digit %0d shows no hex pattern", i);
            end
        end
        check_segments(6, 8'h00);
        check_segments(7, 8'h00);
        if (act !== exp) begin
            errors++;
            $display("ERR peak expected %h actual %h", exp, act);
        end
    endtask

    task automatic check_led_bar(input led_bar_t exp);
        led_bar_t act;
        act = ~LED;
        if (act !== exp) begin
            errors++;
            $display("ERR led_bar expected %h actual %h", exp, act);
        end
    endtask

    task automatic check_mic_pins(input logic [2:0] exp);
        if (GPIO[12:10] !== exp) begin
            errors++;
            $display("ERR GPIO[12:10] expected %h actual %h", exp, GPIO[12:10]);
        end
    endtask

    task automatic check_window(input mic_sample_t w[4], input int n);
        wait_cycle(n * 4 * FRAME_CLK + 16);
        check_peak(max_mag(w));
        check_led_bar(exp_bar(max_mag(w), 1'b0));
    endtask

    task automatic idle_after_reset();
        do_reset();
        wait_cycle(20);
        check_peak('0);
        check_led_bar(exp_bar('0, 1'b0));
        check_mic_pins(3'b100);  // supply high, left channel, ground
    endtask

    task automatic positive_peak();
        mic_sample_t w[4];
        w = '{24'h001234, 24'h05A0F3, 24'h000010, 24'h03FFFF};
        queue_words(w);
        do_reset();
        check_window(w, 1);
    endtask

    task automatic negative_saturation();
        mic_sample_t w[4];
        w = '{24'hFFF000, 24'h800000, 24'h7FFF00, 24'hC00000};
        queue_words(w);
        do_reset();
        check_window(w, 1);
    endtask

    task automatic random_windows();
        mic_sample_t w[3][4];
        foreach (w[n, i])
            w[n][i].value = 24'($random(seed));
        for (int n = 0; n < 3; n++)
            queue_words(w[n]);
        do_reset();
        for (int n = 0; n < 3; n++)
            check_window(w[n], n + 1);
    endtask

    task automatic hold_overflow();
        mic_sample_t kept[4];
        mic_sample_t lost[4];
        mic_sample_t late[4];
        kept = '{24'h000300, 24'hFF0000, 24'h001000, 24'h000020};
        lost = '{24'h7FFFFF, 24'h800000, 24'h700000, 24'h7F0000};
        late = '{24'h000040, 24'h020000, 24'hFFFF00, 24'h000001};
        set_hold(1'b1);
        queue_words(kept);
        queue_words(lost);
        queue_words(late);
        do_reset();
        wait_cycle(8 * FRAME_CLK);
        set_hold(1'b0);
        wait_cycle(8 * FRAME_CLK + 32);
        check_led_bar(exp_bar(max_mag(kept), 1'b1));
        check_peak(max_mag(kept));
        wait_cycle(12 * FRAME_CLK + 32);
        check_led_bar(exp_bar(max_mag(late), 1'b1));
        check_peak(max_mag(late));
    endtask

    task automatic digit_scan();
        mic_sample_t w[4];
        magnitude_t  m;
        w = '{24'h000000, 24'h3A5C1E, 24'h000002, 24'hFFFFFF};
        queue_words(w);
        do_reset();
        check_window(w, 1);
        m = max_mag(w);
        for (int i = 0; i < 6; i++)
            check_segments(i, hex_seg(m[i*4 +: 4]));
    endtask

    initial begin
        #(TOTAL_FRAMES * FRAME_CLK * 20 * 3 / 2);
        $display("run timed out after %0t", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        errors   = 0;
        cyc      = 0;
        seed     = 54342;
        tb_reset = 1'b0;
        hold     = 1'b0;
        sd       = 1'b0;
        pos      = 0;
        ws_last  = 1'b0;
        cur_word = '0;
        wait (!gen_reset);
        idle_after_reset();
        positive_peak();
        negative_saturation();
        random_windows();
        hold_overflow();
        digit_scan();
        $display("tests done, errors %0d", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
src/audio_pkg.sv
src/board_pkg.sv
src/inmp441_mic_i2s_receiver.sv
src/sample_fifo.sv
src/level_meter.sv
src/seg7_display.sv
src/top.sv
src/board_specific_top.sv
tests/tb_clock_gen.sv
tests/board_top_props.sv
tests/tb_board_top.sv

//--- Bender.yml
package:
  name: mic_level_meter

sources:
  - include_dirs:
      - include
    files:
      - src/audio_pkg.sv
      - src/board_pkg.sv
      - src/inmp441_mic_i2s_receiver.sv
      - src/sample_fifo.sv
      - src/level_meter.sv
      - src/seg7_display.sv
      - src/top.sv
      - src/board_specific_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock_gen.sv
      - tests/board_top_props.sv
      - tests/tb_board_top.sv
